/* rv_pipe.f */
+incdir+design
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_fetch.sv
design/rv_regfile.sv
design/rv_forward.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_memory.sv
design/rv_pipe_top.sv
tb/rv_pipe_tb.sv

/* tb/rv_pipe_vectors.txt */
# P addr word = program word, D addr word = preset data word
# E group pc reg value = expected writeback in retire order, all fields hex
P 00000000 00500093
P 00000004 FFD00113
P 00000008 123451B7
P 0000000C 00208233
P 00000010 402082B3
P 00000014 0020F333
P 00000018 0030E3B3
P 0000001C 0020C433
P 00000020 001124B3
P 00000024 00109533
P 00000028 001155B3
P 0000002C 40115633
P 00000030 0F047693
P 00000034 1000E713
P 00000038 FFF14793
P 0000003C FFE12813
P 00000040 01C09893
P 00000044 01C15913
P 00000048 40115993
P 0000004C 00108033
P 00000050 00A00A13
P 00000054 001A0A93
P 00000058 014A8B33
P 0000005C 414B0BB3
P 00000060 015B0C33
P 00000064 017C4CB3
P 00000068 10000D13
P 0000006C 018D2023
P 00000070 013D2223
P 00000074 000D2D83
P 00000078 001D8E13
P 0000007C 004D2E83
P 00000080 01BE8F33
P 00000084 008D2F83
P 00000088 00108463
P 0000008C 06300293
P 00000090 00109463
P 00000094 01100313
P 00000098 00114463
P 0000009C 02200393
P 000000A0 00115463
P 000000A4 03300413
P 000000A8 008004EF
P 000000AC 04400513
P 000000B0 00448613
P 000000B4 00700693
P 000000B8 00069463
P 000000BC 00100713
P 000000C0 0000006F
D 00000108 CAFEF00D
E 1 00000000 01 00000005
E 1 00000004 02 FFFFFFFD
E 1 00000008 03 12345000
E 1 0000000C 04 00000002
E 1 00000010 05 00000008
E 1 00000014 06 00000005
E 1 00000018 07 12345005
E 1 0000001C 08 FFFFFFF8
E 1 00000020 09 00000001
E 1 00000024 0A 000000A0
E 1 00000028 0B 07FFFFFF
E 1 0000002C 0C FFFFFFFF
E 1 00000030 0D 000000F0
E 1 00000034 0E 00000105
E 1 00000038 0F 00000002
E 1 0000003C 10 00000001
E 1 00000040 11 50000000
E 1 00000044 12 0000000F
E 1 00000048 13 FFFFFFFE
E 2 00000050 14 0000000A
E 2 00000054 15 0000000B
E 2 00000058 16 00000015
E 2 0000005C 17 0000000B
E 2 00000060 18 00000020
E 2 00000064 19 0000002B
E 3 00000068 1A 00000100
E 3 00000074 1B 00000020
E 3 00000078 1C 00000021
E 3 0000007C 1D FFFFFFFE
E 3 00000080 1E 0000001E
E 3 00000084 1F CAFEF00D
E 4 00000094 06 00000011
E 4 000000A4 08 00000033
E 4 000000A8 09 000000AC
E 4 000000B0 0C 000000B0
E 4 000000B4 0D 00000007

/* tb/rv_pipe_tb.sv */
// Testbench for the five-stage pipeline
// Clock and reset, instruction and data memory models, vector reader,
// writeback compare tasks, per-group reporting and watchdog
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_tb
    import rv_isa_pkg::*;
();

    localparam int MEM_WORDS = 256;
    localparam int MAX_EXP   = 128;

    logic     clk_cpu;
    logic     arst_n_i;
    word_t    irom_inst_i;
    word_t    dram_rdata_i;
    word_t    irom_addr_o;
    word_t    dram_addr_o;
    word_t    dram_wdata_o;
    logic     dram_we_o;
    logic     debug_wb_have_inst_o;
    word_t    debug_wb_pc_o;
    logic     debug_wb_ena_o;
    reg_idx_t debug_wb_reg_o;
    word_t    debug_wb_value_o;

    word_t    imem [MEM_WORDS];
    word_t    dmem [MEM_WORDS];
    int       exp_group [MAX_EXP];
    word_t    exp_pc [MAX_EXP];
    reg_idx_t exp_reg [MAX_EXP];
    word_t    exp_value [MAX_EXP];
    int       n_prog;
    int       n_exp;
    int       n_seen;
    int       n_checks;
    int       n_errors;
    int       grp_checks_base;
    int       grp_errors_base;
    bit       loaded;
    bit       first_seen;

    rv_pipe_top u_rv_pipe_top (
        .clk_cpu              (clk_cpu),
        .arst_n_i             (arst_n_i),
        .irom_inst_i          (irom_inst_i),
        .dram_rdata_i         (dram_rdata_i),
        .irom_addr_o          (irom_addr_o),
        .dram_addr_o          (dram_addr_o),
        .dram_wdata_o         (dram_wdata_o),
        .dram_we_o            (dram_we_o),
        .debug_wb_have_inst_o (debug_wb_have_inst_o),
        .debug_wb_pc_o        (debug_wb_pc_o),
        .debug_wb_ena_o       (debug_wb_ena_o),
        .debug_wb_reg_o       (debug_wb_reg_o),
        .debug_wb_value_o     (debug_wb_value_o)
    );

    //////////////////////////////////////////////////////////////////////
    // Memory models, combinational read
    assign irom_inst_i  = imem[irom_addr_o[9:2]];
    assign dram_rdata_i = dmem[dram_addr_o[9:2]];

    always @(posedge clk_cpu) begin
        if (dram_we_o) begin
            dmem[dram_addr_o[9:2]] <= dram_wdata_o;
        end
    end

    initial begin
        clk_cpu = 1'b0;
        forever begin
            #4 clk_cpu = ~clk_cpu;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    task automatic check_pc(word_t exp, word_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Fail %0t ns debug_wb_pc_o expected %08h actual %08h", $time, exp, act);
        end
    endtask

    task automatic check_reg(reg_idx_t exp, reg_idx_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Fail %0t ns debug_wb_reg_o expected x%0d actual x%0d", $time, exp, act);
        end
    endtask

    task automatic check_word(word_t exp, word_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Fail %0t ns debug_wb_value_o expected %08h actual %08h",
                     $time, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Fail %0t ns %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    function automatic string group_name(int g);
        case (g)
            0:       return "reset";
            1:       return "alu";
            2:       return "forwarding";
            3:       return "memory";
            4:       return "control";
            default: return "other";
        endcase
    endfunction

    task automatic report_group(int g);
        $display("group %s: %0d checks, %0d errors", group_name(g),
                 n_checks - grp_checks_base, n_errors - grp_errors_base);
        grp_checks_base = n_checks;
        grp_errors_base = n_errors;
    endtask

    // One retiring write against the next expected record
    task automatic compare_retire();
        if (n_seen >= n_exp) begin
            n_errors++;
            $display("Unexpected writeback to x%0d at %0t ns after the last expected record",
                     debug_wb_reg_o, $time);
            return;
        end
        if (debug_wb_reg_o == '0) begin
            n_errors++;
            $display("A write to x0 reached writeback at %0t ns", $time);
        end
        check_pc(exp_pc[n_seen], debug_wb_pc_o);
        check_reg(exp_reg[n_seen], debug_wb_reg_o);
        check_word(exp_value[n_seen], debug_wb_value_o);
        n_seen++;
        if ((n_seen == n_exp) || (exp_group[n_seen] != exp_group[n_seen-1])) begin
            report_group(exp_group[n_seen-1]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Vector reader
    task automatic load_vectors();
        int         fd;
        int         cnt;
        int         ch;
        logic [7:0] kind;
        word_t      a;
        word_t      b;
        word_t      c;
        word_t      d;
        fd = $fopen("tb/rv_pipe_vectors.txt", "r");
        if (fd == 0) begin
            n_errors++;
            $display("Cannot open the vectors file");
            return;
        end
        while ($fscanf(fd, " %c", kind) == 1) begin
            case (kind)
                "#": begin
                    ch = $fgetc(fd);
                    while ((ch != 10) && (ch != -1)) begin
                        ch = $fgetc(fd);
                    end
                end
                "P", "D": begin
                    cnt = $fscanf(fd, "%h %h", a, b);
                    if (kind == "P") begin
                        imem[a[9:2]] = b;
                        n_prog++;
                    end else begin
                        dmem[a[9:2]] = b;
                    end
                end
                "E": begin
                    cnt = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                    if ((cnt == 4) && (n_exp < MAX_EXP)) begin
                        exp_group[n_exp] = int'(a);
                        exp_pc[n_exp]    = b;
                        exp_reg[n_exp]   = reg_idx_t'(c);
                        exp_value[n_exp] = d;
                        n_exp++;
                    end else begin
                        n_errors++;
                        $display("Expected record %0d is malformed or beyond capacity", n_exp);
                    end
                end
                default: begin
                    n_errors++;
                    $display("Unknown record kind in the vectors file");
                end
            endcase
        end
        $fclose(fd);
        if (n_exp == 0) begin
            n_errors++;
            $display("The vectors file holds no expected writebacks");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        arst_n_i = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = 32'h0bad_0000 | word_t'(i);
            dmem[i] = 32'h5a5a_0000 ^ word_t'(i * 4);
        end
        load_vectors();
        loaded = 1'b1;

        // Reset over three rising edges, released just after the third
        repeat (2) begin
            @(negedge clk_cpu);
            check_flag("debug_wb_have_inst_o", 1'b0, debug_wb_have_inst_o);
            check_flag("dram_we_o", 1'b0, dram_we_o);
        end
        @(posedge clk_cpu);
        #1 arst_n_i = 1'b1;
        repeat (3) begin
            @(negedge clk_cpu);
            check_flag("debug_wb_have_inst_o", 1'b0, debug_wb_have_inst_o);
            check_flag("dram_we_o", 1'b0, dram_we_o);
        end

        while (n_seen < n_exp) begin
            @(negedge clk_cpu);
            if (debug_wb_have_inst_o && !first_seen) begin
                first_seen = 1'b1;
                check_pc(32'h0, debug_wb_pc_o);
                report_group(0);
            end
            if (debug_wb_ena_o) begin
                compare_retire();
            end
        end

        // Nothing more may retire once the program parks
        repeat (8) begin
            @(negedge clk_cpu);
            if (debug_wb_ena_o) begin
                compare_retire();
            end
        end

        $display("Summary: %0d of %0d records seen, %0d checks, %0d errors",
                 n_seen, n_exp, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog, three cycles per program word plus pipeline slack
    initial begin
        wait (loaded);
        repeat (n_prog * 3 + 20) @(posedge clk_cpu);
        $display("Watchdog expired after %0d cycles", n_prog * 3 + 20);
        for (int i = n_seen; i < n_exp; i++) begin
            $display("Record %0d never seen: pc %08h x%0d value %08h",
                     i, exp_pc[i], exp_reg[i], exp_value[i]);
        end
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* design/rv_pipe_top.sv */
// Five-stage RV32I subset pipeline top
// Stage instances, register file, forwarding unit, debug outputs
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_top
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire        clk_cpu,
    input  wire        arst_n_i,
    input  wire word_t irom_inst_i,
    input  wire word_t dram_rdata_i,
    output word_t      irom_addr_o,
    output word_t      dram_addr_o,
    output word_t      dram_wdata_o,
    output logic       dram_we_o,
    output logic       debug_wb_have_inst_o,
    output word_t      debug_wb_pc_o,
    output logic       debug_wb_ena_o,
    output reg_idx_t   debug_wb_reg_o,
    output word_t      debug_wb_value_o
);

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    redirect_t redirect;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     mem_wdata;
    fwd_sel_e  id_sel1;
    fwd_sel_e  id_sel2;
    fwd_sel_e  ex_sel1;
    fwd_sel_e  ex_sel2;

    //////////////////////////////////////////////////////////////////////
    // Stages
    rv_fetch u_fetch (
        .clk_cpu     (clk_cpu),
        .arst_n_i    (arst_n_i),
        .irom_inst_i (irom_inst_i),
        .redirect_i  (redirect),
        .irom_addr_o (irom_addr_o),
        .if_id_o     (if_id)
    );

    rv_decode u_decode (
        .clk_cpu     (clk_cpu),
        .arst_n_i    (arst_n_i),
        .if_id_i     (if_id),
        .rs1_val_i   (rs1_val),
        .rs2_val_i   (rs2_val),
        .mem_wdata_i (mem_wdata),
        .wb_i        (mem_wb),
        .id_sel1_i   (id_sel1),
        .id_sel2_i   (id_sel2),
        .id_ex_o     (id_ex)
    );

    rv_regfile u_regfile (
        .clk_cpu   (clk_cpu),
        .arst_n_i  (arst_n_i),
        .rs1_i     (if_id.inst[19:15]),
        .rs2_i     (if_id.inst[24:20]),
        .wb_i      (mem_wb),
        .rs1_val_o (rs1_val),
        .rs2_val_o (rs2_val)
    );

    rv_forward u_forward (
        .if_id_i   (if_id),
        .id_ex_i   (id_ex),
        .ex_mem_i  (ex_mem),
        .mem_wb_i  (mem_wb),
        .id_sel1_o (id_sel1),
        .id_sel2_o (id_sel2),
        .ex_sel1_o (ex_sel1),
        .ex_sel2_o (ex_sel2)
    );

    rv_execute u_execute (
        .clk_cpu     (clk_cpu),
        .arst_n_i    (arst_n_i),
        .id_ex_i     (id_ex),
        .mem_wdata_i (mem_wdata),
        .wb_wdata_i  (mem_wb.wdata),
        .ex_sel1_i   (ex_sel1),
        .ex_sel2_i   (ex_sel2),
        .ex_mem_o    (ex_mem),
        .redirect_o  (redirect)
    );

    rv_memory u_memory (
        .clk_cpu      (clk_cpu),
        .arst_n_i     (arst_n_i),
        .ex_mem_i     (ex_mem),
        .dram_rdata_i (dram_rdata_i),
        .dram_addr_o  (dram_addr_o),
        .dram_wdata_o (dram_wdata_o),
        .dram_we_o    (dram_we_o),
        .mem_wdata_o  (mem_wdata),
        .mem_wb_o     (mem_wb)
    );

    // Writeback debug view
    assign debug_wb_have_inst_o = mem_wb.have_inst;
    assign debug_wb_pc_o        = mem_wb.pc;
    assign debug_wb_ena_o       = mem_wb.rf_we;
    assign debug_wb_reg_o       = mem_wb.rd;
    assign debug_wb_value_o     = mem_wb.wdata;

endmodule

`default_nettype wire

/* design/rv_memory.sv */
// Memory stage
// Data memory drive, writeback value select, MEM/WB register
`timescale 1ns/1ps
`default_nettype none

module rv_memory
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire          clk_cpu,
    input  wire          arst_n_i,
    input  wire ex_mem_t ex_mem_i,
    input  wire word_t   dram_rdata_i,
    output word_t        dram_addr_o,
    output word_t        dram_wdata_o,
    output logic         dram_we_o,
    output word_t        mem_wdata_o,
    output mem_wb_t      mem_wb_o
);

    assign dram_addr_o  = ex_mem_i.alu_c;
    assign dram_wdata_o = ex_mem_i.store_data;
    assign dram_we_o    = ex_mem_i.dram_we;

    // Also feeds the MEM-stage forward path, load data included
    always_comb begin
        case (ex_mem_i.wb_sel)
            WB_MEM:  mem_wdata_o = dram_rdata_i;
            WB_PC4:  mem_wdata_o = ex_mem_i.pc4;
            default: mem_wdata_o = ex_mem_i.alu_c;
        endcase
    end

    always_ff @(posedge clk_cpu or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_wb_o <= '0;
        end else begin
            mem_wb_o.have_inst <= ex_mem_i.have_inst;
            mem_wb_o.pc        <= ex_mem_i.pc;
            mem_wb_o.rf_we     <= ex_mem_i.rf_we;
            mem_wb_o.rd        <= ex_mem_i.rd;
            mem_wb_o.wdata     <= mem_wdata_o;
        end
    end

endmodule

`default_nettype wire

/* design/rv_execute.sv */
// Execute stage
// Execute-side forwarding, ALU, branch compare, redirect to fetch,
// EX/MEM register
`timescale 1ns/1ps
`default_nettype none

module rv_execute
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire           clk_cpu,
    input  wire           arst_n_i,
    input  wire id_ex_t   id_ex_i,
    input  wire word_t    mem_wdata_i,
    input  wire word_t    wb_wdata_i,
    input  wire fwd_sel_e ex_sel1_i,
    input  wire fwd_sel_e ex_sel2_i,
    output ex_mem_t       ex_mem_o,
    output redirect_t     redirect_o
);

    ctrl_t ctrl;
    word_t src_a;
    word_t src_b;
    word_t alu_a;
    word_t alu_b;
    word_t alu_c;
    logic  br_met;

    assign ctrl  = id_ex_i.ctrl;
    assign src_a = fwd_mux(ex_sel1_i, id_ex_i.rs1_val, mem_wdata_i, wb_wdata_i);
    assign src_b = fwd_mux(ex_sel2_i, id_ex_i.rs2_val, mem_wdata_i, wb_wdata_i);
    assign alu_a = ctrl.a_is_pc ? id_ex_i.pc : src_a;
    assign alu_b = ctrl.b_is_imm ? id_ex_i.imm : src_b;

    //////////////////////////////////////////////////////////////////////
    // ALU
    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_c = alu_a + alu_b;
            ALU_SUB:    alu_c = alu_a - alu_b;
            ALU_AND:    alu_c = alu_a & alu_b;
            ALU_OR:     alu_c = alu_a | alu_b;
            ALU_XOR:    alu_c = alu_a ^ alu_b;
            ALU_SLT:    alu_c = word_t'($signed(alu_a) < $signed(alu_b));
            ALU_SLL:    alu_c = alu_a << alu_b[4:0];
            ALU_SRL:    alu_c = alu_a >> alu_b[4:0];
            ALU_SRA:    alu_c = word_t'($signed(alu_a) >>> alu_b[4:0]);
            ALU_PASS_B: alu_c = alu_b;
            default:    alu_c = '0;
        endcase
    end

    // Branch compare on the forwarded register values
    always_comb begin
        case (ctrl.br_cond)
            BR_EQ:   br_met = (src_a == src_b);
            BR_NE:   br_met = (src_a != src_b);
            BR_LT:   br_met = ($signed(src_a) < $signed(src_b));
            BR_GE:   br_met = ($signed(src_a) >= $signed(src_b));
            default: br_met = 1'b0;
        endcase
    end

    // Target is pc + imm out of the ALU
    assign redirect_o.taken  = ctrl.jump || br_met;
    assign redirect_o.target = alu_c;

    //////////////////////////////////////////////////////////////////////
    // EX/MEM register
    always_ff @(posedge clk_cpu or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o.have_inst  <= id_ex_i.have_inst;
            ex_mem_o.pc         <= id_ex_i.pc;
            ex_mem_o.alu_c      <= alu_c;
            ex_mem_o.store_data <= src_b;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.pc4        <= id_ex_i.pc + word_t'(4);
            ex_mem_o.dram_we    <= ctrl.dram_we;
            ex_mem_o.rf_we      <= ctrl.rf_we;
            ex_mem_o.wb_sel     <= ctrl.wb_sel;
        end
    end

endmodule

`default_nettype wire

/* design/rv_decode.sv */
// Decode stage
// Control decode, immediate build, decode-side forwarding,
// ID/EX register
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_defines.svh"

module rv_decode
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire           clk_cpu,
    input  wire           arst_n_i,
    input  wire if_id_t   if_id_i,
    input  wire word_t    rs1_val_i,
    input  wire word_t    rs2_val_i,
    input  wire word_t    mem_wdata_i,
    input  wire mem_wb_t  wb_i,
    input  wire fwd_sel_e id_sel1_i,
    input  wire fwd_sel_e id_sel2_i,
    output id_ex_t        id_ex_o
);

    word_t      inst;
    opcode_t    opcode;
    logic [2:0] funct3;
    reg_idx_t   rd;
    word_t      imm;
    ctrl_t      ctrl;

    assign inst   = if_id_i.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];

    // SUB exists only in the register form
    function automatic alu_op_e alu_decode(logic [2:0] f3, logic f7b5, logic is_reg);
        case (f3)
            3'b000:  return (is_reg && f7b5) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b101:  return f7b5 ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Controls and immediates
    always_comb begin
        ctrl = '0;
        imm  = '0;
        if (if_id_i.have_inst) begin
            case (opcode)
                `RV_OP_OP: begin
                    ctrl.alu_op = alu_decode(funct3, inst[30], 1'b1);
                    ctrl.rf_we  = 1'b1;
                end
                `RV_OP_IMM: begin
                    ctrl.alu_op   = alu_decode(funct3, inst[30], 1'b0);
                    ctrl.b_is_imm = 1'b1;
                    ctrl.rf_we    = 1'b1;
                    imm           = {{20{inst[31]}}, inst[31:20]};
                end
                `RV_OP_LUI: begin
                    ctrl.alu_op   = ALU_PASS_B;
                    ctrl.b_is_imm = 1'b1;
                    ctrl.rf_we    = 1'b1;
                    imm           = {inst[31:12], 12'b0};
                end
                `RV_OP_LOAD: begin
                    ctrl.b_is_imm = 1'b1;
                    ctrl.rf_we    = 1'b1;
                    ctrl.wb_sel   = WB_MEM;
                    imm           = {{20{inst[31]}}, inst[31:20]};
                end
                `RV_OP_STORE: begin
                    ctrl.b_is_imm = 1'b1;
                    ctrl.dram_we  = 1'b1;
                    imm           = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                end
                `RV_OP_BRANCH: begin
                    // ALU forms the target, compare uses the register operands
                    ctrl.a_is_pc  = 1'b1;
                    ctrl.b_is_imm = 1'b1;
                    imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                    case (funct3)
                        3'b000:  ctrl.br_cond = BR_EQ;
                        3'b001:  ctrl.br_cond = BR_NE;
                        3'b100:  ctrl.br_cond = BR_LT;
                        3'b101:  ctrl.br_cond = BR_GE;
                        default: ctrl.br_cond = BR_NONE;
                    endcase
                end
                `RV_OP_JAL: begin
                    ctrl.jump     = 1'b1;
                    ctrl.a_is_pc  = 1'b1;
                    ctrl.b_is_imm = 1'b1;
                    ctrl.rf_we    = 1'b1;
                    ctrl.wb_sel   = WB_PC4;
                    imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                end
                default: begin
                    ctrl = '0;
                end
            endcase
            // No writes to x0
            if (rd == '0) begin
                ctrl.rf_we = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // ID/EX register
    always_ff @(posedge clk_cpu or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o.have_inst <= if_id_i.have_inst;
            id_ex_o.pc        <= if_id_i.pc;
            id_ex_o.rs1_val   <= fwd_mux(id_sel1_i, rs1_val_i, mem_wdata_i, wb_i.wdata);
            id_ex_o.rs2_val   <= fwd_mux(id_sel2_i, rs2_val_i, mem_wdata_i, wb_i.wdata);
            id_ex_o.imm       <= imm;
            id_ex_o.rs1       <= inst[19:15];
            id_ex_o.rs2       <= inst[24:20];
            id_ex_o.rd        <= rd;
            id_ex_o.ctrl      <= ctrl;
        end
    end

endmodule

`default_nettype wire

/* design/rv_forward.sv */
// Forwarding unit
// Source selects for decode and execute operands, MEM before WB
`timescale 1ns/1ps
`default_nettype none

module rv_forward
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire if_id_t  if_id_i,
    input  wire id_ex_t  id_ex_i,
    input  wire ex_mem_t ex_mem_i,
    input  wire mem_wb_t mem_wb_i,
    output fwd_sel_e     id_sel1_o,
    output fwd_sel_e     id_sel2_o,
    output fwd_sel_e     ex_sel1_o,
    output fwd_sel_e     ex_sel2_o
);

    function automatic fwd_sel_e pick(reg_idx_t src, ex_mem_t em, mem_wb_t mw);
        if ((src != '0) && em.rf_we && (em.rd == src)) begin
            return FWD_MEM;
        end
        if ((src != '0) && mw.rf_we && (mw.rd == src)) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    // Decode side reads straight from the fetched word
    assign id_sel1_o = pick(if_id_i.inst[19:15], ex_mem_i, mem_wb_i);
    assign id_sel2_o = pick(if_id_i.inst[24:20], ex_mem_i, mem_wb_i);
    assign ex_sel1_o = pick(id_ex_i.rs1, ex_mem_i, mem_wb_i);
    assign ex_sel2_o = pick(id_ex_i.rs2, ex_mem_i, mem_wb_i);

endmodule

`default_nettype wire

/* design/rv_regfile.sv */
// Register file
// 31 writable registers, x0 reads as zero, two read ports
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire           clk_cpu,
    input  wire           arst_n_i,
    input  wire reg_idx_t rs1_i,
    input  wire reg_idx_t rs2_i,
    input  wire mem_wb_t  wb_i,
    output word_t         rs1_val_o,
    output word_t         rs2_val_o
);

    word_t regs_q [1:31];

    always_ff @(posedge clk_cpu or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.rf_we && (wb_i.rd != '0)) begin
            regs_q[wb_i.rd] <= wb_i.wdata;
        end
    end

    // Old value on a same-cycle write
    assign rs1_val_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rs2_val_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

`default_nettype wire

/* design/rv_fetch.sv */
// Fetch stage
// PC register, stall FSM for branches and JAL, IF/ID register
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_defines.svh"

module rv_fetch
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire            clk_cpu,
    input  wire            arst_n_i,
    input  wire word_t     irom_inst_i,
    input  wire redirect_t redirect_i,
    output word_t          irom_addr_o,
    output if_id_t         if_id_o
);

    typedef enum logic [1:0] {RUN, WAIT1, WAIT2} fetch_state_e;

    fetch_state_e state_q;
    word_t        pc_q;
    logic [1:0]   wait_cnt_q;
    opcode_t      opcode;
    logic         is_ctrl;

    assign opcode      = irom_inst_i[6:0];
    assign is_ctrl     = (opcode == `RV_OP_BRANCH) || (opcode == `RV_OP_JAL);
    assign irom_addr_o = pc_q;

    //////////////////////////////////////////////////////////////////////
    // PC and stall FSM
    always_ff @(posedge clk_cpu or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= RUN;
            pc_q       <= `RV_RESET_PC;
            wait_cnt_q <= '0;
        end else begin
            case (state_q)
                RUN: begin
                    pc_q <= pc_q + word_t'(4);
                    if (is_ctrl) begin
                        state_q    <= WAIT1;
                        wait_cnt_q <= '0;
                    end
                end
                WAIT1: begin
                    wait_cnt_q <= wait_cnt_q + 2'd1;
                    if (wait_cnt_q == 2'(`RV_CTRL_STALL - 2)) begin
                        state_q <= WAIT2;
                    end
                end
                default: begin
                    // Transfer sits in execute this cycle
                    if (redirect_i.taken) begin
                        pc_q <= redirect_i.target;
                    end
                    state_q <= RUN;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // IF/ID register
    always_ff @(posedge clk_cpu or negedge arst_n_i) begin
        if (!arst_n_i) begin
            if_id_o <= '0;
        end else begin
            if_id_o.have_inst <= (state_q == RUN);
            if_id_o.pc        <= pc_q;
            if_id_o.inst      <= irom_inst_i;
        end
    end

endmodule

`default_nettype wire

/* design/rv_pipe_pkg.sv */
// Pipeline types
// Forwarding select, control bundle, stage-register structs,
// branch redirect and the shared forwarding mux
`default_nettype none

package rv_pipe_pkg;
    import rv_isa_pkg::*;

    typedef enum logic [1:0] {
        FWD_NONE, FWD_MEM, FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e  alu_op;
        br_cond_e br_cond;
        logic     jump;
        logic     a_is_pc;
        logic     b_is_imm;
        logic     dram_we;
        logic     rf_we;
        wb_sel_e  wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic  have_inst;
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        logic     have_inst;
        word_t    pc;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        ctrl_t    ctrl;
    } id_ex_t;

    typedef struct packed {
        logic     have_inst;
        word_t    pc;
        word_t    alu_c;
        word_t    store_data;
        reg_idx_t rd;
        word_t    pc4;
        logic     dram_we;
        logic     rf_we;
        wb_sel_e  wb_sel;
    } ex_mem_t;

    typedef struct packed {
        logic     have_inst;
        word_t    pc;
        logic     rf_we;
        reg_idx_t rd;
        word_t    wdata;
    } mem_wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    // Operand pick shared by decode and execute
    function automatic word_t fwd_mux(fwd_sel_e sel, word_t rf_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

endpackage

`default_nettype wire

/* design/rv_isa_pkg.sv */
// Instruction-set types
// Data word, register index, opcode field, ALU operation,
// branch condition and writeback source
`default_nettype none
`include "rv_pipe_defines.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0]  word_t;
    typedef logic [`RV_REG_W-1:0] reg_idx_t;
    typedef logic [6:0]           opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_e;

    // BR_NONE marks a non-branch
    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE
    } br_cond_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_PC4
    } wb_sel_e;

endpackage

`default_nettype wire

/* design/rv_pipe_defines.svh */
// Datapath widths, reset PC and control-transfer stall depth
// Major opcode values of the kept RV32I instructions
`ifndef RV_PIPE_DEFINES_SVH
`define RV_PIPE_DEFINES_SVH

// Widths
`define RV_XLEN        32
`define RV_REG_W       5

// Fetch
`define RV_RESET_PC    32'h0000_0000
`define RV_CTRL_STALL  2

// Opcodes
`define RV_OP_OP       7'b0110011
`define RV_OP_IMM      7'b0010011
`define RV_OP_LUI      7'b0110111
`define RV_OP_LOAD     7'b0000011
`define RV_OP_STORE    7'b0100011
`define RV_OP_BRANCH   7'b1100011
`define RV_OP_JAL      7'b1101111

`endif
